//--- hdl/issue_pkg.sv
package issue_pkg;

    localparam int unsigned NUM_ARCH_REGS = 32;
    localparam int unsigned SB_DEPTH      = 8;
    localparam int unsigned XLEN          = 32;

    localparam int unsigned ARCH_REG_W = $clog2(NUM_ARCH_REGS);
    localparam int unsigned SB_ID_W    = $clog2(SB_DEPTH);
    localparam int unsigned SB_CNT_W   = $clog2(SB_DEPTH + 1); // must reach SB_DEPTH
    localparam int unsigned FU_OP_W    = 8;
    localparam int unsigned PC_W       = 32;

    // architectural register index, x0..x31
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // scoreboard slot, doubles as trans id towards the ex unit
    typedef logic [SB_ID_W-1:0] sb_id_t;

    // occupancy, 0..SB_DEPTH
    typedef logic [SB_CNT_W-1:0] sb_cnt_t;

    typedef logic [XLEN-1:0] xlen_t;

    // opaque to the issue stage, passed on to ex
    typedef logic [FU_OP_W-1:0] fu_op_t;

    typedef logic [PC_W-1:0] pc_t;

endpackage

//--- hdl/rename_table.sv
`timescale 1ns/1ns

module rename_table (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,

    // decode lookup
    input  issue_pkg::arch_reg_t rs1_i,
    input  issue_pkg::arch_reg_t rs2_i,
    output logic                 rs1_renamed_o,
    output logic                 rs2_renamed_o,
    output issue_pkg::sb_id_t    rs1_id_o,
    output issue_pkg::sb_id_t    rs2_id_o,

    // new producer
    input  logic                 alloc_i,
    input  issue_pkg::arch_reg_t alloc_rd_i,
    input  issue_pkg::sb_id_t    alloc_id_i,

    // producer leaving the scoreboard
    input  logic                 retire_i,
    input  issue_pkg::arch_reg_t retire_rd_i,
    input  issue_pkg::sb_id_t    retire_id_i
);

    logic [issue_pkg::NUM_ARCH_REGS-1:0] map_valid_q;
    issue_pkg::sb_id_t                   map_id_q [issue_pkg::NUM_ARCH_REGS];

    logic                                do_alloc;
    logic                                do_clear;

    assign do_alloc = alloc_i && (alloc_rd_i != '0); // x0 stays architectural

    // only drop the mapping if nobody newer has claimed rd
    assign do_clear = retire_i
                   && map_valid_q[retire_rd_i]
                   && (map_id_q[retire_rd_i] == retire_id_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_valid_q <= '0;
        end else if (flush_i) begin
            map_valid_q <= '0;
        end else begin
            if (do_clear) begin
                map_valid_q[retire_rd_i] <= 1'b0;
            end
            if (do_alloc) begin
                map_valid_q[alloc_rd_i] <= 1'b1; // alloc wins on same rd
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_alloc) begin
            map_id_q[alloc_rd_i] <= alloc_id_i;
        end
    end

    assign rs1_renamed_o = map_valid_q[rs1_i];
    assign rs2_renamed_o = map_valid_q[rs2_i];
    assign rs1_id_o      = map_id_q[rs1_i];
    assign rs2_id_o      = map_id_q[rs2_i];

endmodule

//--- hdl/sb_queue_ctrl.sv
`timescale 1ns/1ns

module sb_queue_ctrl (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,

    input  logic              push_i,
    input  logic              issue_i,
    input  logic              pop_i,

    output issue_pkg::sb_id_t wr_ptr_o,
    output issue_pkg::sb_id_t issue_ptr_o,
    output issue_pkg::sb_id_t commit_ptr_o,
    output logic              full_o,
    output logic              empty_o
);

    issue_pkg::sb_id_t  wr_ptr_q;
    issue_pkg::sb_id_t  issue_ptr_q;
    issue_pkg::sb_id_t  commit_ptr_q;
    issue_pkg::sb_cnt_t cnt_q;

    logic               do_push;
    logic               do_pop;

    assign full_o  = (cnt_q == issue_pkg::sb_cnt_t'(issue_pkg::SB_DEPTH));
    assign empty_o = (cnt_q == '0);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q     <= '0;
            issue_ptr_q  <= '0;
            commit_ptr_q <= '0;
            cnt_q        <= '0;
        end else if (flush_i) begin
            wr_ptr_q     <= '0;
            issue_ptr_q  <= '0;
            commit_ptr_q <= '0;
            cnt_q        <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (issue_i) begin
                issue_ptr_q <= issue_ptr_q + 1'b1;
            end
            if (do_pop) begin
                commit_ptr_q <= commit_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q; // both or neither
            endcase
        end
    end

    assign wr_ptr_o     = wr_ptr_q;
    assign issue_ptr_o  = issue_ptr_q;
    assign commit_ptr_o = commit_ptr_q;

endmodule

//--- hdl/scoreboard.sv
`timescale 1ns/1ns

module scoreboard (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,

    // decode side
    input  logic                 decode_valid_i,
    output logic                 decode_ready_o,
    input  issue_pkg::arch_reg_t dec_rd_i,
    input  issue_pkg::fu_op_t    dec_op_i,
    input  issue_pkg::pc_t       dec_pc_i,
    input  logic                 rs1_renamed_i,
    input  logic                 rs2_renamed_i,
    input  issue_pkg::sb_id_t    rs1_id_i,
    input  issue_pkg::sb_id_t    rs2_id_i,
    input  issue_pkg::xlen_t     rf_rdata_a_i,
    input  issue_pkg::xlen_t     rf_rdata_b_i,

    // writeback
    input  logic                 wb_valid_i,
    input  issue_pkg::sb_id_t    wb_trans_id_i,
    input  issue_pkg::xlen_t     wb_data_i,

    // issue to ex
    input  logic                 ex_ready_i,
    output logic                 issue_valid_o,
    output issue_pkg::fu_op_t    issue_op_o,
    output issue_pkg::pc_t       issue_pc_o,
    output issue_pkg::sb_id_t    issue_trans_id_o,
    output issue_pkg::xlen_t     issue_operand_a_o,
    output issue_pkg::xlen_t     issue_operand_b_o,

    // commit to regfile
    input  logic                 commit_ack_i,
    output logic                 commit_valid_o,
    output issue_pkg::pc_t       commit_pc_o,
    output logic                 rf_we_o,
    output issue_pkg::arch_reg_t rf_waddr_o,
    output issue_pkg::xlen_t     rf_wdata_o,
    output issue_pkg::arch_reg_t retire_rd_o,

    // queue control
    input  issue_pkg::sb_id_t    wr_ptr_i,
    input  issue_pkg::sb_id_t    issue_ptr_i,
    input  issue_pkg::sb_id_t    commit_ptr_i,
    input  logic                 full_i,
    output logic                 push_o,
    output logic                 issue_o,
    output logic                 pop_o
);

    localparam int unsigned NSRC = 2; // rs1, rs2

    // per-entry control
    logic [issue_pkg::SB_DEPTH-1:0]           busy_q;
    logic [issue_pkg::SB_DEPTH-1:0]           issued_q;
    logic [issue_pkg::SB_DEPTH-1:0]           done_q;
    logic [issue_pkg::SB_DEPTH-1:0][NSRC-1:0] src_rdy_q;

    // per-entry payload
    issue_pkg::pc_t       pc_q       [issue_pkg::SB_DEPTH];
    issue_pkg::fu_op_t    op_q       [issue_pkg::SB_DEPTH];
    issue_pkg::arch_reg_t rd_q       [issue_pkg::SB_DEPTH];
    issue_pkg::sb_id_t    src_pend_q [issue_pkg::SB_DEPTH][NSRC];
    issue_pkg::xlen_t     src_data_q [issue_pkg::SB_DEPTH][NSRC];
    issue_pkg::xlen_t     result_q   [issue_pkg::SB_DEPTH];

    // incoming sources, indexed by source
    logic [NSRC-1:0]      dec_renamed;
    issue_pkg::sb_id_t    dec_id  [NSRC];
    issue_pkg::xlen_t     dec_rf  [NSRC];
    logic [NSRC-1:0]      new_rdy;
    issue_pkg::xlen_t     new_data [NSRC];

    logic [issue_pkg::SB_DEPTH-1:0][NSRC-1:0] wake;

    assign dec_renamed = {rs2_renamed_i, rs1_renamed_i};
    assign dec_id[0]   = rs1_id_i;
    assign dec_id[1]   = rs2_id_i;
    assign dec_rf[0]   = rf_rdata_a_i;
    assign dec_rf[1]   = rf_rdata_b_i;

    // forwarding priority: same-cycle wb, then finished producer, else wait
    always_comb begin : operand_select
        for (int s = 0; s < NSRC; s++) begin
            new_rdy[s]  = 1'b1;
            new_data[s] = dec_rf[s];
            if (dec_renamed[s]) begin
                if (wb_valid_i && (wb_trans_id_i == dec_id[s])) begin
                    new_data[s] = wb_data_i;
                end else if (done_q[dec_id[s]]) begin
                    new_data[s] = result_q[dec_id[s]];
                end else begin
                    new_rdy[s] = 1'b0;
                end
            end
        end
    end

    always_comb begin : wakeup
        for (int j = 0; j < issue_pkg::SB_DEPTH; j++) begin
            for (int s = 0; s < NSRC; s++) begin
                wake[j][s] = wb_valid_i && busy_q[j] && !src_rdy_q[j][s]
                          && (src_pend_q[j][s] == wb_trans_id_i);
            end
        end
    end

    assign decode_ready_o = !full_i;
    assign push_o         = decode_valid_i && !full_i;

    assign issue_valid_o  = busy_q[issue_ptr_i] && !issued_q[issue_ptr_i]
                         && (&src_rdy_q[issue_ptr_i]);
    assign issue_o        = issue_valid_o && ex_ready_i;

    assign commit_valid_o = busy_q[commit_ptr_i] && done_q[commit_ptr_i];
    assign pop_o          = commit_valid_o && commit_ack_i;
    assign rf_we_o        = pop_o && (rd_q[commit_ptr_i] != '0); // x0 is never written

    always_ff @(posedge clk_i or negedge rst_ni) begin : entry_ctrl
        if (!rst_ni) begin
            busy_q    <= '0;
            issued_q  <= '0;
            done_q    <= '0;
            src_rdy_q <= '0;
        end else if (flush_i) begin
            busy_q   <= '0;
            issued_q <= '0;
            done_q   <= '0;
        end else begin
            if (pop_o) begin
                busy_q[commit_ptr_i]   <= 1'b0;
                issued_q[commit_ptr_i] <= 1'b0;
                done_q[commit_ptr_i]   <= 1'b0;
            end
            if (push_o) begin
                busy_q[wr_ptr_i]    <= 1'b1;
                issued_q[wr_ptr_i]  <= 1'b0;
                done_q[wr_ptr_i]    <= 1'b0;
                src_rdy_q[wr_ptr_i] <= new_rdy;
            end
            if (issue_o) begin
                issued_q[issue_ptr_i] <= 1'b1;
            end
            if (wb_valid_i) begin
                done_q[wb_trans_id_i] <= 1'b1;
            end
            for (int j = 0; j < issue_pkg::SB_DEPTH; j++) begin
                for (int s = 0; s < NSRC; s++) begin
                    if (wake[j][s]) begin
                        src_rdy_q[j][s] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin : entry_data
        if (push_o) begin
            pc_q[wr_ptr_i] <= dec_pc_i;
            op_q[wr_ptr_i] <= dec_op_i;
            rd_q[wr_ptr_i] <= dec_rd_i;
            for (int s = 0; s < NSRC; s++) begin
                src_pend_q[wr_ptr_i][s] <= dec_id[s];
                src_data_q[wr_ptr_i][s] <= new_data[s];
            end
        end
        if (wb_valid_i) begin
            result_q[wb_trans_id_i] <= wb_data_i;
        end
        for (int j = 0; j < issue_pkg::SB_DEPTH; j++) begin
            for (int s = 0; s < NSRC; s++) begin
                if (wake[j][s]) begin
                    src_data_q[j][s] <= wb_data_i;
                end
            end
        end
    end

    // held stable by the entry while ex stalls
    assign issue_op_o        = op_q[issue_ptr_i];
    assign issue_pc_o        = pc_q[issue_ptr_i];
    assign issue_trans_id_o  = issue_ptr_i;
    assign issue_operand_a_o = src_data_q[issue_ptr_i][0];
    assign issue_operand_b_o = src_data_q[issue_ptr_i][1];

    assign commit_pc_o = pc_q[commit_ptr_i];
    assign rf_waddr_o  = rd_q[commit_ptr_i];
    assign rf_wdata_o  = result_q[commit_ptr_i];
    assign retire_rd_o = rd_q[commit_ptr_i];

endmodule

//--- hdl/instr_issue.sv
`timescale 1ns/1ns

module instr_issue (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,

    // decode
    input  logic                 decode_valid_i,
    output logic                 decode_ready_o,
    input  issue_pkg::arch_reg_t decode_rs1_i,
    input  issue_pkg::arch_reg_t decode_rs2_i,
    input  issue_pkg::arch_reg_t decode_rd_i,
    input  issue_pkg::fu_op_t    decode_op_i,
    input  issue_pkg::pc_t       decode_pc_i,

    // regfile read, answered same cycle
    output issue_pkg::arch_reg_t rf_raddr_a_o,
    output issue_pkg::arch_reg_t rf_raddr_b_o,
    input  issue_pkg::xlen_t     rf_rdata_a_i,
    input  issue_pkg::xlen_t     rf_rdata_b_i,

    // issue
    output logic                 issue_valid_o,
    output issue_pkg::fu_op_t    issue_op_o,
    output issue_pkg::pc_t       issue_pc_o,
    output issue_pkg::sb_id_t    issue_trans_id_o,
    output issue_pkg::xlen_t     issue_operand_a_o,
    output issue_pkg::xlen_t     issue_operand_b_o,
    input  logic                 ex_ready_i,

    // writeback
    input  logic                 wb_valid_i,
    input  issue_pkg::sb_id_t    wb_trans_id_i,
    input  issue_pkg::xlen_t     wb_data_i,

    // commit
    output logic                 commit_valid_o,
    input  logic                 commit_ack_i,
    output issue_pkg::pc_t       commit_pc_o,
    output logic                 rf_we_o,
    output issue_pkg::arch_reg_t rf_waddr_o,
    output issue_pkg::xlen_t     rf_wdata_o
);

    logic                 rs1_renamed;
    logic                 rs2_renamed;
    issue_pkg::sb_id_t    rs1_id;
    issue_pkg::sb_id_t    rs2_id;
    logic                 push;
    logic                 issue;
    logic                 pop;
    issue_pkg::sb_id_t    wr_ptr;
    issue_pkg::sb_id_t    issue_ptr;
    issue_pkg::sb_id_t    commit_ptr;
    logic                 full;
    issue_pkg::arch_reg_t retire_rd;

    assign rf_raddr_a_o = decode_rs1_i;
    assign rf_raddr_b_o = decode_rs2_i;

    rename_table i_rename_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .rs1_i         (decode_rs1_i),
        .rs2_i         (decode_rs2_i),
        .rs1_renamed_o (rs1_renamed),
        .rs2_renamed_o (rs2_renamed),
        .rs1_id_o      (rs1_id),
        .rs2_id_o      (rs2_id),
        .alloc_i       (push),
        .alloc_rd_i    (decode_rd_i),
        .alloc_id_i    (wr_ptr),
        .retire_i      (pop),
        .retire_rd_i   (retire_rd),
        .retire_id_i   (commit_ptr)
    );

    sb_queue_ctrl i_sb_queue_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .push_i       (push),
        .issue_i      (issue),
        .pop_i        (pop),
        .wr_ptr_o     (wr_ptr),
        .issue_ptr_o  (issue_ptr),
        .commit_ptr_o (commit_ptr),
        .full_o       (full),
        .empty_o      ()
    );

    scoreboard i_scoreboard (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .decode_valid_i    (decode_valid_i),
        .decode_ready_o    (decode_ready_o),
        .dec_rd_i          (decode_rd_i),
        .dec_op_i          (decode_op_i),
        .dec_pc_i          (decode_pc_i),
        .rs1_renamed_i     (rs1_renamed),
        .rs2_renamed_i     (rs2_renamed),
        .rs1_id_i          (rs1_id),
        .rs2_id_i          (rs2_id),
        .rf_rdata_a_i      (rf_rdata_a_i),
        .rf_rdata_b_i      (rf_rdata_b_i),
        .wb_valid_i        (wb_valid_i),
        .wb_trans_id_i     (wb_trans_id_i),
        .wb_data_i         (wb_data_i),
        .ex_ready_i        (ex_ready_i),
        .issue_valid_o     (issue_valid_o),
        .issue_op_o        (issue_op_o),
        .issue_pc_o        (issue_pc_o),
        .issue_trans_id_o  (issue_trans_id_o),
        .issue_operand_a_o (issue_operand_a_o),
        .issue_operand_b_o (issue_operand_b_o),
        .commit_ack_i      (commit_ack_i),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .rf_we_o           (rf_we_o),
        .rf_waddr_o        (rf_waddr_o),
        .rf_wdata_o        (rf_wdata_o),
        .retire_rd_o       (retire_rd),
        .wr_ptr_i          (wr_ptr),
        .issue_ptr_i       (issue_ptr),
        .commit_ptr_i      (commit_ptr),
        .full_i            (full),
        .push_o            (push),
        .issue_o           (issue),
        .pop_o             (pop)
    );

endmodule

//--- testbench/instr_issue_asserts.sv
`timescale 1ns/1ns

module instr_issue_asserts (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 flush_i,
    input logic                 decode_ready_o,
    input logic                 issue_valid_o,
    input issue_pkg::fu_op_t    issue_op_o,
    input issue_pkg::pc_t       issue_pc_o,
    input issue_pkg::sb_id_t    issue_trans_id_o,
    input issue_pkg::xlen_t     issue_operand_a_o,
    input issue_pkg::xlen_t     issue_operand_b_o,
    input logic                 ex_ready_i,
    input logic                 commit_valid_o,
    input logic                 commit_ack_i,
    input logic                 rf_we_o,
    input issue_pkg::arch_reg_t rf_waddr_o
);

    int fail_cnt = 0;

    reset_idle: assert property (@(posedge clk_i)
        !rst_ni |-> !issue_valid_o && !commit_valid_o && !rf_we_o && decode_ready_o)
        else begin
            fail_cnt++;
            $error("outputs are not idle while reset is held");
        end

    // stalled issue keeps the whole payload
    issue_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_o && !ex_ready_i && !flush_i |=> issue_valid_o
            && $stable(issue_op_o) && $stable(issue_pc_o) && $stable(issue_trans_id_o)
            && $stable(issue_operand_a_o) && $stable(issue_operand_b_o))
        else begin
            fail_cnt++;
            $error("issue outputs changed while the execution unit stalled");
        end

    issue_id_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_o && ex_ready_i && !flush_i
            |=> issue_trans_id_o == issue_pkg::sb_id_t'($past(issue_trans_id_o) + 3'd1))
        else begin
            fail_cnt++;
            $error("issue id did not advance by one after an issue");
        end

    rf_write_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rf_we_o |-> commit_valid_o && commit_ack_i && (rf_waddr_o != '0))
        else begin
            fail_cnt++;
            $error("register file write outside a commit or to x0");
        end

    flush_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !issue_valid_o && !commit_valid_o && decode_ready_o)
        else begin
            fail_cnt++;
            $error("scoreboard not empty after a flush");
        end

endmodule

bind instr_issue instr_issue_asserts u_asserts (.*);

//--- testbench/tb_instr_issue.sv
`timescale 1ns/1ns

module tb_instr_issue;

    localparam int N_RAND  = 200;
    localparam int N_TOTAL = N_RAND + 16; // plus backpressure and flush

    logic                 clk_i, rst_ni, flush_i;
    logic                 decode_valid_i, decode_ready_o;
    issue_pkg::arch_reg_t decode_rs1_i, decode_rs2_i, decode_rd_i;
    issue_pkg::fu_op_t    decode_op_i, issue_op_o;
    issue_pkg::pc_t       decode_pc_i, issue_pc_o, commit_pc_o;
    issue_pkg::arch_reg_t rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
    issue_pkg::xlen_t     rf_rdata_a_i, rf_rdata_b_i, rf_wdata_o, wb_data_i;
    issue_pkg::xlen_t     issue_operand_a_o, issue_operand_b_o;
    issue_pkg::sb_id_t    issue_trans_id_o, wb_trans_id_i;
    logic                 issue_valid_o, ex_ready_i, wb_valid_i;
    logic                 commit_valid_o, commit_ack_i, rf_we_o;

    issue_pkg::xlen_t     rf_mem [issue_pkg::NUM_ARCH_REGS];
    logic [31:0]          lfsr = 32'h3479a8c2;

    // reference model indexed by program order
    int                   last_wr [issue_pkg::NUM_ARCH_REGS]; // youngest writer or -1
    int                   cmt_wr [issue_pkg::NUM_ARCH_REGS];
    int                   wr_a [512], wr_b [512], id_of [512];
    issue_pkg::arch_reg_t rs1_of [512], rs2_of [512], rd_of [512];
    issue_pkg::fu_op_t    op_of [512];
    issue_pkg::xlen_t     result [512];
    int                   iss_q [$], cmt_q [$], ex_q [$];
    int                   seq_n, exp_id, n_pass, n_fail, err_total, test_err, asrt_seen;
    bit                   gaps, dec_on, ex_on, ack_on;
    string                test_name;

    instr_issue dut0 (.*);

    assign rf_rdata_a_i = rf_mem[rf_raddr_a_o];
    assign rf_rdata_b_i = rf_mem[rf_raddr_b_o];

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < issue_pkg::NUM_ARCH_REGS; r++) begin
                rf_mem[r] <= 32'(r) ^ 32'h1000;
            end
        end else if (rf_we_o) begin
            rf_mem[rf_waddr_o] <= rf_wdata_o;
        end
    end

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    initial begin
        #(40 * N_TOTAL * 100);
        $display("timeout, the tests did not finish within %0d cycles", 40 * N_TOTAL);
        $display("Simulation failed");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // mostly x1..x4 to force dependencies
    function automatic issue_pkg::arch_reg_t pick_reg();
        logic [2:0] roll;
        roll = 3'(take_bits(3));
        if (roll > 3'd1) begin
            return issue_pkg::arch_reg_t'(take_bits(2) + 1);
        end
        if (roll == 3'd1) begin
            return '0; // x0 now and then
        end
        return issue_pkg::arch_reg_t'(take_bits(5));
    endfunction

    function automatic issue_pkg::xlen_t src_value(input int wr, input issue_pkg::arch_reg_t r);
        return (wr < 0) ? (32'(r) ^ 32'h1000) : result[wr];
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_err++;
        end
    endtask

    // drive on the falling edge and account for the coming rising edge
    task automatic step();
        int s;
        @(negedge clk_i);
        decode_valid_i = dec_on && (!gaps || take_bits(2) != 0);
        decode_rs1_i   = pick_reg();
        decode_rs2_i   = pick_reg();
        decode_rd_i    = pick_reg();
        decode_op_i    = issue_pkg::fu_op_t'(take_bits(8));
        decode_pc_i    = issue_pkg::pc_t'(seq_n * 4);
        ex_ready_i     = ex_on && (!gaps || take_bits(1) != 0);
        commit_ack_i   = ack_on && (!gaps || take_bits(2) != 0);
        wb_valid_i     = (ex_q.size() != 0) && (!gaps || take_bits(1) != 0);
        if (wb_valid_i) begin
            s             = ex_q.pop_front();
            wb_trans_id_i = issue_pkg::sb_id_t'(id_of[s]);
            wb_data_i     = result[s];
        end
        #1;
        if (decode_valid_i && decode_ready_o) begin
            s         = seq_n;
            seq_n     = seq_n + 1;
            rs1_of[s] = decode_rs1_i;
            rs2_of[s] = decode_rs2_i;
            rd_of[s]  = decode_rd_i;
            op_of[s]  = decode_op_i;
            wr_a[s]   = last_wr[decode_rs1_i];
            wr_b[s]   = last_wr[decode_rs2_i];
            id_of[s]  = exp_id;
            exp_id    = (exp_id + 1) % issue_pkg::SB_DEPTH;
            if (decode_rd_i != '0) begin
                last_wr[decode_rd_i] = s;
            end
            iss_q.push_back(s);
            cmt_q.push_back(s);
        end
        if (issue_valid_o && ex_ready_i) begin
            s = iss_q.pop_front();
            result[s] = src_value(wr_a[s], rs1_of[s]) + src_value(wr_b[s], rs2_of[s]) + id_of[s];
            check("issue id", id_of[s], issue_trans_id_o);
            check("issue op", op_of[s], issue_op_o);
            check("issue pc", s * 4, issue_pc_o);
            check("operand a", src_value(wr_a[s], rs1_of[s]), issue_operand_a_o);
            check("operand b", src_value(wr_b[s], rs2_of[s]), issue_operand_b_o);
            ex_q.push_back(s);
        end
        if (commit_valid_o && commit_ack_i) begin
            s = cmt_q.pop_front();
            check("commit rd", rd_of[s], rf_waddr_o);
            check("commit data", result[s], rf_wdata_o);
            check("commit pc", s * 4, commit_pc_o);
            check("rf_we", rd_of[s] != '0, rf_we_o);
            if (rd_of[s] != '0) begin
                cmt_wr[rd_of[s]] = s;
            end
        end
    endtask

    task automatic do_flush();
        @(negedge clk_i);
        flush_i        = 1'b1;
        decode_valid_i = 1'b0;
        ex_ready_i     = 1'b0;
        wb_valid_i     = 1'b0;
        commit_ack_i   = 1'b0;
        @(negedge clk_i);
        flush_i = 1'b0;
        check("issue_valid after flush", 0, issue_valid_o);
        check("commit_valid after flush", 0, commit_valid_o);
        check("decode_ready after flush", 1, decode_ready_o);
        iss_q.delete();
        cmt_q.delete();
        ex_q.delete();
        exp_id  = 0;
        last_wr = cmt_wr; // sources fall back to the register file
    endtask

    task automatic end_test();
        @(posedge clk_i); // let the last accounted edge reach the assertions
        #1;
        test_err += dut0.u_asserts.fail_cnt - asrt_seen;
        asrt_seen = dut0.u_asserts.fail_cnt;
        if (test_err == 0) begin
            $display("test %s: passed", test_name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_err);
            n_fail++;
        end
        err_total += test_err;
        test_err = 0;
    endtask

    initial begin
        int start;
        for (int r = 0; r < issue_pkg::NUM_ARCH_REGS; r++) begin
            last_wr[r] = -1;
            cmt_wr[r]  = -1;
        end
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        decode_valid_i = 1'b0;
        decode_rs1_i   = '0;
        decode_rs2_i   = '0;
        decode_rd_i    = '0;
        decode_op_i    = '0;
        decode_pc_i    = '0;
        ex_ready_i     = 1'b0;
        wb_valid_i     = 1'b0;
        wb_trans_id_i  = '0;
        wb_data_i      = '0;
        commit_ack_i   = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_name = "reset";
        check("issue_valid", 0, issue_valid_o);
        check("commit_valid", 0, commit_valid_o);
        check("rf_we", 0, rf_we_o);
        check("decode_ready", 1, decode_ready_o);
        end_test();

        test_name = "random";
        {gaps, dec_on, ex_on, ack_on} = 4'b1111;
        while (seq_n < N_RAND) step();
        dec_on = 1'b0;
        while (cmt_q.size() != 0) step();
        end_test();

        test_name = "backpressure";
        {gaps, dec_on, ex_on, ack_on} = 4'b0110; // commit held off
        start = seq_n;
        while (decode_ready_o) step();
        check("accepted decodes", issue_pkg::SB_DEPTH, seq_n - start);
        step();
        check("decodes while full", issue_pkg::SB_DEPTH, seq_n - start);
        {dec_on, ack_on} = 2'b01;
        while (cmt_q.size() != 0) step();
        end_test();

        test_name = "flush";
        {gaps, dec_on, ex_on, ack_on} = 4'b1110;
        start = seq_n;
        while (seq_n < start + 4) step();
        do_flush();
        ack_on = 1'b1;
        start  = seq_n;
        while (seq_n < start + 4) step();
        dec_on = 1'b0;
        while (cmt_q.size() != 0) step();
        end_test();

        $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, err_total);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- instr_issue.f
hdl/issue_pkg.sv
hdl/rename_table.sv
hdl/sb_queue_ctrl.sv
hdl/scoreboard.sv
hdl/instr_issue.sv
testbench/instr_issue_asserts.sv
testbench/tb_instr_issue.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, then run and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_instr_issue \
    -f instr_issue.f -o tb_sim || exit 1
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
